//--- hw/invaders_pkg.sv
package invaders_pkg;

    // Screen coordinates and color
    localparam int X_W     = 10;
    localparam int Y_W     = 9;
    localparam int COLOR_W = 9;

    localparam logic [COLOR_W-1:0] COLOR_BLACK = 9'b000_000_000;
    localparam logic [COLOR_W-1:0] COLOR_RED   = 9'b111_000_000;

    // Object geometry in pixels
    localparam int MISSILE_LEN   = 25;
    localparam int MISSILE_THICK = 3;
    localparam int ALIEN_SIZE    = 32;
    localparam int LAUNCH_OFFSET = 16;

    // Register map in byte addresses of 32-bit words
    localparam logic [7:0] REG_CTRL       = 8'h00;
    localparam logic [7:0] REG_STATUS     = 8'h04;
    localparam logic [7:0] REG_ALIEN_POS  = 8'h08;
    localparam logic [7:0] REG_LAUNCH_POS = 8'h0C;
    localparam logic [7:0] REG_SCORE      = 8'h10;

    typedef enum logic [1:0] {
        mode_menu  = 2'd0,
        mode_clear = 2'd1,
        mode_play  = 2'd2
    } game_mode_t;

    // One pixel write toward the frame buffer
    typedef struct packed {
        logic               write;
        logic [X_W-1:0]     x;
        logic [Y_W-1:0]     y;
        logic [COLOR_W-1:0] color;
    } pixel_wr_t;

    // AXI4-Lite channels driven by the master
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    // AXI4-Lite channels driven by the slave
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [X_W-1:0] alien_x;
        logic [Y_W-1:0] alien_y;
        logic [X_W-1:0] launch_x;
        logic [Y_W-1:0] launch_y;
        logic           start_pulse;
        logic           fire_pulse;
    } game_cfg_t;

    typedef struct packed {
        game_mode_t mode;
        logic       missile_active;
        logic       alien_alive;
        logic [7:0] score;
    } game_status_t;

endpackage

//--- hw/game_regs.sv
`timescale 1ns/1ps

module game_regs (
    input  logic                       Clock,
    input  logic                       reset,
    input  invaders_pkg::axil_req_t    axil_req,
    output invaders_pkg::axil_rsp_t    axil_rsp,
    input  invaders_pkg::game_status_t status,
    output invaders_pkg::game_cfg_t    cfg
);
    import invaders_pkg::*;

    logic           wr_en;
    logic           rd_en;
    logic           bvalid;
    logic           rvalid;
    logic [31:0]    rdata;
    logic [31:0]    read_word;
    logic [31:0]    alien_next;
    logic [31:0]    launch_next;
    logic [X_W-1:0] alien_x;
    logic [Y_W-1:0] alien_y;
    logic [X_W-1:0] launch_x;
    logic [Y_W-1:0] launch_y;

    // Position word with x low and y in the upper half
    function automatic logic [31:0] pos_word(input logic [X_W-1:0] x, input logic [Y_W-1:0] y);
        return {7'd0, y, 6'd0, x};
    endfunction

    // Byte lane merge of a write into an old word
    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] word;
        word = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                word[8*i +: 8] = data[8*i +: 8];
        end
        return word;
    endfunction

    // ========================================
    // Write channel
    // ========================================
    // Address and data are taken together, never while a response is pending
    assign wr_en = axil_req.awvalid && axil_req.wvalid && !bvalid;

    assign alien_next  = merge_word(pos_word(alien_x, alien_y), axil_req.wdata, axil_req.wstrb);
    assign launch_next = merge_word(pos_word(launch_x, launch_y), axil_req.wdata, axil_req.wstrb);

    always_ff @(posedge Clock) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            alien_x  <= '0;
            alien_y  <= '0;
            launch_x <= '0;
            launch_y <= '0;
        end else if (wr_en) begin
            case (axil_req.awaddr)
                REG_ALIEN_POS: begin
                    alien_x <= alien_next[X_W-1:0];
                    alien_y <= alien_next[16 +: Y_W];
                end
                REG_LAUNCH_POS: begin
                    launch_x <= launch_next[X_W-1:0];
                    launch_y <= launch_next[16 +: Y_W];
                end
                default: begin
                end
            endcase
        end
    end

    // ========================================
    // Read channel
    // ========================================
    assign rd_en = axil_req.arvalid && !rvalid;

    always_comb begin
        case (axil_req.araddr)
            REG_STATUS:     read_word = {28'd0, status.alien_alive, status.missile_active,
                                         status.mode};
            REG_ALIEN_POS:  read_word = pos_word(alien_x, alien_y);
            REG_LAUNCH_POS: read_word = pos_word(launch_x, launch_y);
            REG_SCORE:      read_word = {24'd0, status.score};
            default:        read_word = 32'd0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read data is held with rvalid until the master takes it
    always_ff @(posedge Clock) begin
        if (rd_en)
            rdata <= read_word;
    end

    assign axil_rsp = '{awready: wr_en, wready: wr_en, bvalid: bvalid, bresp: 2'b00,
                        arready: rd_en, rvalid: rvalid, rdata: rdata, rresp: 2'b00};

    // Control bits live only for the accepting cycle
    assign cfg = '{alien_x: alien_x, alien_y: alien_y, launch_x: launch_x, launch_y: launch_y,
                   start_pulse: wr_en && axil_req.awaddr == REG_CTRL && axil_req.wstrb[0]
                                && axil_req.wdata[0],
                   fire_pulse:  wr_en && axil_req.awaddr == REG_CTRL && axil_req.wstrb[0]
                                && axil_req.wdata[1]};

endmodule

//--- hw/game_control.sv
`timescale 1ns/1ps

module game_control (
    input  logic                     Clock,
    input  logic                     reset,
    input  logic                     start_pulse,
    input  logic                     clear_done,
    input  invaders_pkg::pixel_wr_t  clear_pix,
    input  invaders_pkg::pixel_wr_t  missile_pix,
    output invaders_pkg::game_mode_t mode,
    output invaders_pkg::pixel_wr_t  pix
);
    import invaders_pkg::*;

    game_mode_t next_mode;

    // Menu waits for start, clear waits for the sweep, play is final
    always_comb begin
        next_mode = mode;
        case (mode)
            mode_menu:  if (start_pulse) next_mode = mode_clear;
            mode_clear: if (clear_done) next_mode = mode_play;
            mode_play:  next_mode = mode_play;
            default:    next_mode = mode_menu;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset)
            mode <= mode_menu;
        else
            mode <= next_mode;
    end

    // Pixel source of the current mode
    always_comb begin
        case (mode)
            mode_clear: pix = clear_pix;
            mode_play:  pix = missile_pix;
            default:    pix = '0;
        endcase
    end

endmodule

//--- hw/screen_clear.sv
`timescale 1ns/1ps

module screen_clear #(
    parameter int COLS = 640,
    parameter int ROWS = 480
) (
    input  logic                    Clock,
    input  logic                    reset,
    input  logic                    enable,
    output logic                    done,
    output invaders_pkg::pixel_wr_t pix
);
    import invaders_pkg::*;

    logic           running;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;

    // Single raster pass, x fastest, then done holds for good
    always_ff @(posedge Clock) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            x       <= '0;
            y       <= '0;
        end else if (enable && !running && !done) begin
            running <= 1'b1;
        end else if (running) begin
            if (x == X_W'(COLS - 1)) begin
                x <= '0;
                if (y == Y_W'(ROWS - 1)) begin
                    y       <= '0;
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    assign pix = '{write: running, x: x, y: y, color: COLOR_BLACK};

endmodule

//--- hw/missile_engine.sv
`timescale 1ns/1ps

module missile_engine #(
    parameter int COLS        = 640,
    parameter int MOVE_PERIOD = 65536
) (
    input  logic                           Clock,
    input  logic                           reset,
    input  logic                           fire,
    input  logic                           armed,
    input  logic [invaders_pkg::X_W-1:0]   launch_x,
    input  logic [invaders_pkg::Y_W-1:0]   launch_y,
    input  logic                           hit,
    output invaders_pkg::pixel_wr_t        pix,
    output logic [invaders_pkg::X_W-1:0]   pos_x,
    output logic [invaders_pkg::Y_W-1:0]   pos_y,
    output logic                           active
);
    import invaders_pkg::*;

    localparam int XC_W = $clog2(MISSILE_LEN);
    localparam int YC_W = $clog2(MISSILE_THICK);
    localparam int PC_W = $clog2(MOVE_PERIOD + 1);

    typedef enum logic [2:0] {
        st_idle, st_init, st_draw, st_wait, st_erase, st_move, st_done
    } state_t;

    state_t          state;
    state_t          next_state;
    logic [XC_W-1:0] xc;
    logic [YC_W-1:0] yc;
    logic [PC_W-1:0] wait_cnt;
    logic            hit_seen;
    logic            fire_ok;
    logic            box_last;
    logic            period_end;
    logic [X_W:0]    next_x;

    assign fire_ok    = fire && armed && (state == st_idle || state == st_done);
    assign box_last   = (xc == XC_W'(MISSILE_LEN - 1)) && (yc == YC_W'(MISSILE_THICK - 1));
    assign period_end = (wait_cnt == PC_W'(MOVE_PERIOD - 1));
    assign next_x     = {1'b0, pos_x} + 1'b1;

    // ========================================
    // State sequence
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            st_idle, st_done: if (fire_ok) next_state = st_init;
            st_init:  next_state = st_draw;
            st_draw:  if (box_last) next_state = st_wait;
            st_wait:  if (hit || hit_seen || period_end) next_state = st_erase;
            st_erase: begin
                if (box_last)
                    next_state = (hit || hit_seen) ? st_done : st_move;
            end
            st_move:  next_state = (next_x >= COLS) ? st_done : st_draw;
            default:  next_state = st_idle;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            state    <= st_idle;
            hit_seen <= 1'b0;
            xc       <= '0;
            yc       <= '0;
            wait_cnt <= '0;
        end else begin
            state <= next_state;
            // A hit anywhere in the flight ends it after the next erase
            hit_seen <= (state == st_init) ? hit : (hit_seen | hit);
            case (state)
                st_init: begin
                    xc <= '0;
                    yc <= '0;
                end
                st_draw, st_erase: begin
                    wait_cnt <= '0;
                    if (xc == XC_W'(MISSILE_LEN - 1)) begin
                        xc <= '0;
                        yc <= (yc == YC_W'(MISSILE_THICK - 1)) ? '0 : yc + 1'b1;
                    end else begin
                        xc <= xc + 1'b1;
                    end
                end
                st_wait: wait_cnt <= wait_cnt + 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Launch point latched in the accepting cycle, then one step right per move
    always_ff @(posedge Clock) begin
        if (fire_ok) begin
            pos_x <= launch_x + X_W'(LAUNCH_OFFSET);
            pos_y <= launch_y;
        end else if (state == st_move) begin
            pos_x <= next_x[X_W-1:0];
        end
    end

    assign active = (state != st_idle) && (state != st_done);

    assign pix = '{write: (state == st_draw) || (state == st_erase),
                   x:     pos_x + X_W'(xc),
                   y:     pos_y + Y_W'(yc),
                   color: (state == st_erase) ? COLOR_BLACK : COLOR_RED};

endmodule

//--- hw/hit_score.sv
`timescale 1ns/1ps

module hit_score (
    input  logic                         Clock,
    input  logic                         reset,
    input  logic [invaders_pkg::X_W-1:0] missile_x,
    input  logic [invaders_pkg::Y_W-1:0] missile_y,
    input  logic                         missile_active,
    input  logic [invaders_pkg::X_W-1:0] alien_x,
    input  logic [invaders_pkg::Y_W-1:0] alien_y,
    output logic                         hit,
    output logic                         alien_alive,
    output logic [7:0]                   score
);
    import invaders_pkg::*;

    localparam int HALF = ALIEN_SIZE / 2;

    logic x_overlap;
    logic y_overlap;
    logic hit_d;

    // Alien box is shifted up by HALF on both sides of each compare
    // so that nothing goes below zero near the screen edge
    assign x_overlap = ({1'b0, missile_x} <= {1'b0, alien_x} + (X_W + 1)'(HALF - 1))
                    && ({1'b0, missile_x} + (X_W + 1)'(MISSILE_LEN - 1 + HALF)
                        >= {1'b0, alien_x});
    assign y_overlap = ({1'b0, missile_y} <= {1'b0, alien_y} + (Y_W + 1)'(HALF - 1))
                    && ({1'b0, missile_y} + (Y_W + 1)'(MISSILE_THICK - 1 + HALF)
                        >= {1'b0, alien_y});

    assign hit = alien_alive && missile_active && x_overlap && y_overlap;

    always_ff @(posedge Clock) begin
        if (reset) begin
            hit_d       <= 1'b0;
            alien_alive <= 1'b1;
            score       <= 8'd0;
        end else begin
            hit_d <= hit;
            if (hit && !hit_d) begin
                score       <= score + 8'd1;
                alien_alive <= 1'b0;
            end
        end
    end

endmodule

//--- hw/invaders_top.sv
`timescale 1ns/1ps

module invaders_top #(
    parameter int COLS        = 640,
    parameter int ROWS        = 480,
    parameter int MOVE_PERIOD = 65536
) (
    input  logic                    Clock,
    input  logic                    reset,
    input  invaders_pkg::axil_req_t axil_req,
    output invaders_pkg::axil_rsp_t axil_rsp,
    output invaders_pkg::pixel_wr_t pix
);
    import invaders_pkg::*;

    game_cfg_t      cfg;
    game_status_t   status;
    game_mode_t     mode;
    pixel_wr_t      clear_pix;
    pixel_wr_t      missile_pix;
    logic           clear_done;
    logic           hit;
    logic           missile_active;
    logic           alien_alive;
    logic [7:0]     score;
    logic [X_W-1:0] missile_x;
    logic [Y_W-1:0] missile_y;

    assign status = '{mode: mode, missile_active: missile_active,
                      alien_alive: alien_alive, score: score};

    // ========================================
    // Register block and mode control
    // ========================================
    game_regs u_regs (
        .Clock    (Clock),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .status   (status),
        .cfg      (cfg)
    );

    game_control u_control (
        .Clock       (Clock),
        .reset       (reset),
        .start_pulse (cfg.start_pulse),
        .clear_done  (clear_done),
        .clear_pix   (clear_pix),
        .missile_pix (missile_pix),
        .mode        (mode),
        .pix         (pix)
    );

    screen_clear #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) u_clear (
        .Clock  (Clock),
        .reset  (reset),
        .enable (mode == mode_clear),
        .done   (clear_done),
        .pix    (clear_pix)
    );

    // ========================================
    // Missile and target
    // ========================================
    missile_engine #(
        .COLS        (COLS),
        .MOVE_PERIOD (MOVE_PERIOD)
    ) u_missile (
        .Clock    (Clock),
        .reset    (reset),
        .fire     (cfg.fire_pulse),
        .armed    (mode == mode_play),
        .launch_x (cfg.launch_x),
        .launch_y (cfg.launch_y),
        .hit      (hit),
        .pix      (missile_pix),
        .pos_x    (missile_x),
        .pos_y    (missile_y),
        .active   (missile_active)
    );

    hit_score u_hit (
        .Clock          (Clock),
        .reset          (reset),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active),
        .alien_x        (cfg.alien_x),
        .alien_y        (cfg.alien_y),
        .hit            (hit),
        .alien_alive    (alien_alive),
        .score          (score)
    );

endmodule

//--- tests/tb_invaders.sv
`timescale 1ns/1ps

module tb_invaders;
    import invaders_pkg::*;

    localparam int COLS        = 64;
    localparam int ROWS        = 16;
    localparam int MOVE_PERIOD = 16;
    localparam int CYCLE_LIMIT = 40000;

    // Missile geometry and the launch point used by the tests
    localparam int BOX_W      = 25;
    localparam int BOX_H      = 3;
    localparam int BOX_PIXELS = BOX_W * BOX_H;
    localparam int OFFSET     = 16;
    localparam int LAUNCH_X   = 10;
    localparam int LAUNCH_Y   = 5;
    localparam logic [8:0] RED   = 9'h1C0;
    localparam logic [8:0] BLACK = 9'h000;

    logic      Clock;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    pixel_wr_t pix;

    pixel_wr_t   writes[$];
    int          write_cycle[$];
    int          cycle_count = 0;
    int          errors;
    int          test_mark;
    int          tests_passed;
    int          tests_failed;

    invaders_top #(
        .COLS        (COLS),
        .ROWS        (ROWS),
        .MOVE_PERIOD (MOVE_PERIOD)
    ) u_dut (
        .Clock    (Clock),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .pix      (pix)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // Pixel writes are stable by the falling edge
    always @(negedge Clock) begin
        if (pix.write) begin
            writes.push_back(pix);
            write_cycle.push_back(cycle_count);
        end
    end

    always @(posedge Clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: no finish after %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ========================================
    // Check helpers
    // ========================================
    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_box(input int first, input int left, input int top,
                             input logic [8:0] color);
        assert (writes.size() >= first + BOX_PIXELS) else begin
            $display("box at x %0d is missing pixel writes, only %0d arrived", left,
                     writes.size());
            errors++;
        end
        // Rows top to bottom, x left to right, one write per cycle
        for (int i = 0; i < BOX_PIXELS && first + i < writes.size(); i++) begin
            check_equal("pix.x", left + i % BOX_W, writes[first + i].x);
            check_equal("pix.y", top + i / BOX_W, writes[first + i].y);
            check_equal("pix.color", color, writes[first + i].color);
            check_equal("pix cycle", write_cycle[first] + i, write_cycle[first + i]);
        end
    endtask

    // Whole flight from the launch point until the next step would leave the screen
    task automatic check_flight();
        int idx;
        idx = 0;
        for (int left = LAUNCH_X + OFFSET; left < COLS; left++) begin
            check_box(idx, left, LAUNCH_Y, RED);
            check_box(idx + BOX_PIXELS, left, LAUNCH_Y, BLACK);
            idx += 2 * BOX_PIXELS;
        end
        check_equal("flight write count", idx, writes.size());
    endtask

    task automatic start_test();
        test_mark = errors;
        writes.delete();
        write_cycle.delete();
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_mark) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_mark);
        end
    endtask

    // ========================================
    // AXI4-Lite master
    // ========================================
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge Clock);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        axil_req.bready  <= 1'b1;
        @(negedge Clock);
        while (!(axil_rsp.awready && axil_rsp.wready))
            @(negedge Clock);
        @(posedge Clock);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge Clock);
        while (!axil_rsp.bvalid)
            @(negedge Clock);
        check_equal("bresp", 2'b00, axil_rsp.bresp);
        @(posedge Clock);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge Clock);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        @(negedge Clock);
        while (!axil_rsp.arready)
            @(negedge Clock);
        @(posedge Clock);
        axil_req.arvalid <= 1'b0;
        @(negedge Clock);
        while (!axil_rsp.rvalid)
            @(negedge Clock);
        data = axil_rsp.rdata;
        check_equal("rresp", 2'b00, axil_rsp.rresp);
        @(posedge Clock);
        axil_req.rready <= 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input string name,
                               input logic [31:0] expected);
        logic [31:0] data;
        axil_read(addr, data);
        check_equal(name, expected, data);
    endtask

    task automatic wait_writes(input int count);
        while (writes.size() < count)
            @(negedge Clock);
    endtask

    // Polls STATUS until the missile active bit drops
    task automatic wait_missile_idle();
        logic [31:0] st;
        st = 32'h4;
        while (st[2]) begin
            repeat (8) @(posedge Clock);
            axil_read(REG_STATUS, st);
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    initial begin
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        axil_req <= '0;
        reset    <= 1'b1;
        repeat (2) @(posedge Clock);
        reset <= 1'b0;

        start_test();
        @(negedge Clock);
        check_equal("awready", 0, axil_rsp.awready);
        check_equal("wready", 0, axil_rsp.wready);
        check_equal("bvalid", 0, axil_rsp.bvalid);
        check_equal("arready", 0, axil_rsp.arready);
        check_equal("rvalid", 0, axil_rsp.rvalid);
        check_equal("pix.write", 0, pix.write);
        // Menu, missile idle, alien alive
        read_expect(REG_STATUS, "status", 32'h8);
        read_expect(REG_SCORE, "score", 32'h0);
        axil_write(REG_ALIEN_POS, (32'd400 << 16) | 32'd500);
        axil_write(REG_LAUNCH_POS, (32'(LAUNCH_Y) << 16) | 32'(LAUNCH_X));
        read_expect(REG_ALIEN_POS, "alien_pos", 32'h0190_01F4);
        read_expect(REG_LAUNCH_POS, "launch_pos", 32'h0005_000A);
        axil_write(REG_CTRL, 32'h2);
        repeat (20) @(posedge Clock);
        check_equal("menu write count", 0, writes.size());
        read_expect(REG_STATUS, "status", 32'h8);
        end_test(1, "reset and registers");

        start_test();
        axil_write(REG_CTRL, 32'h1);
        wait_writes(COLS * ROWS);
        repeat (4) @(posedge Clock);
        check_equal("clear write count", COLS * ROWS, writes.size());
        for (int i = 0; i < COLS * ROWS && i < writes.size(); i++) begin
            check_equal("pix.x", i % COLS, writes[i].x);
            check_equal("pix.y", i / COLS, writes[i].y);
            check_equal("pix.color", BLACK, writes[i].color);
            check_equal("pix cycle", write_cycle[0] + i, write_cycle[i]);
        end
        read_expect(REG_STATUS, "status", 32'hA);
        writes.delete();
        write_cycle.delete();
        axil_write(REG_CTRL, 32'h1);
        repeat (20) @(posedge Clock);
        check_equal("restart write count", 0, writes.size());
        end_test(2, "screen clear");

        start_test();
        axil_write(REG_CTRL, 32'h2);
        wait_writes(3 * BOX_PIXELS);
        check_box(0, LAUNCH_X + OFFSET, LAUNCH_Y, RED);
        check_box(BOX_PIXELS, LAUNCH_X + OFFSET, LAUNCH_Y, BLACK);
        check_equal("wait gap", MOVE_PERIOD + 1,
                    write_cycle[BOX_PIXELS] - write_cycle[BOX_PIXELS - 1]);
        check_box(2 * BOX_PIXELS, LAUNCH_X + OFFSET + 1, LAUNCH_Y, RED);
        end_test(3, "missile draw and move");

        // Same flight as test 3, so the queue is kept
        test_mark = errors;
        wait_missile_idle();
        check_flight();
        read_expect(REG_STATUS, "status", 32'hA);
        read_expect(REG_SCORE, "score", 32'h0);
        end_test(4, "missile flight");

        start_test();
        axil_write(REG_ALIEN_POS, (32'd6 << 16) | 32'd40);
        axil_write(REG_CTRL, 32'h2);
        wait_missile_idle();
        check_equal("hit write count", 2 * BOX_PIXELS, writes.size());
        check_box(0, LAUNCH_X + OFFSET, LAUNCH_Y, RED);
        check_box(BOX_PIXELS, LAUNCH_X + OFFSET, LAUNCH_Y, BLACK);
        assert (write_cycle[BOX_PIXELS] - write_cycle[BOX_PIXELS - 1] <= MOVE_PERIOD)
        else begin
            $display("erase after the hit did not come before the full move period");
            errors++;
        end
        read_expect(REG_SCORE, "score", 32'h1);
        read_expect(REG_STATUS, "status", 32'h2);
        writes.delete();
        write_cycle.delete();
        axil_write(REG_CTRL, 32'h2);
        wait_missile_idle();
        check_flight();
        read_expect(REG_SCORE, "score", 32'h1);
        end_test(5, "hit and score");

        $display("tests passed %0d failed %0d, %0d errors", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- list.f
hw/invaders_pkg.sv
hw/game_regs.sv
hw/game_control.sv
hw/screen_clear.sv
hw/missile_engine.sv
hw/hit_score.sv
hw/invaders_top.sv
tests/tb_invaders.sv

//--- run.sh
#!/bin/sh
# Build and run the invaders testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_invaders -f list.f -o sim_invaders

./obj_dir/sim_invaders > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation finished without errors"
